// File: hdl/attn_pkg.sv
package attn_pkg;

  // ==========================================================================
  // constants
  // ==========================================================================

  // index field width inside items, tiles up to 64x64
  localparam int unsigned MAX_IDX_W = 6;

  localparam logic [31:0] FP32_NINF     = 32'hFF80_0000;
  localparam logic [31:0] FP32_POS_ZERO = 32'h0000_0000;

  // ==========================================================================
  // fp32 word, raw view and field view
  // ==========================================================================
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    fp32_fields_t fields;
  } fp32_t;

  // score tagged with its tile position
  typedef struct packed {
    logic                 valid;
    logic [MAX_IDX_W-1:0] row;
    logic [MAX_IDX_W-1:0] col;
    fp32_t                value;
  } score_item_t;

  // subtractor request, item plus the max of its row
  typedef struct packed {
    score_item_t item;
    fp32_t       rowmax;
  } sub_req_t;

  typedef enum logic {
    PASS_MAX = 1'b0,
    PASS_SUB = 1'b1
  } sweep_pass_t;

endpackage

// File: hdl/score_buffer.sv
`timescale 1ns/1ps

module score_buffer #(
  parameter  int unsigned T     = 8,
  localparam int unsigned IDX_W = $clog2(T)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   host_we_i,
  input  logic                   host_re_i,
  input  logic [IDX_W-1:0]       host_row_i,
  input  logic [IDX_W-1:0]       host_col_i,
  input  attn_pkg::fp32_t        host_wdata_i,
  output attn_pkg::fp32_t        host_rdata_o,
  output logic                   host_rvalid_o,
  input  logic                   eng_re_i,
  input  logic [IDX_W-1:0]       eng_row_i,
  input  logic [IDX_W-1:0]       eng_col_i,
  output attn_pkg::score_item_t  eng_item_o,
  input  attn_pkg::score_item_t  wb_item_i
);
  import attn_pkg::*;

  fp32_t            mem [T][T];
  logic             eng_valid_q;
  logic [IDX_W-1:0] eng_row_q;
  logic [IDX_W-1:0] eng_col_q;
  fp32_t            eng_value_q;

  // write-back from the engine wins over the host
  always_ff @(posedge clk) begin
    if (wb_item_i.valid) begin
      mem[wb_item_i.row[IDX_W-1:0]][wb_item_i.col[IDX_W-1:0]] <= wb_item_i.value;
    end else if (host_we_i) begin
      mem[host_row_i][host_col_i] <= host_wdata_i;
    end
  end

  // read data paths
  always_ff @(posedge clk) begin
    host_rdata_o <= mem[host_row_i][host_col_i];
    eng_value_q  <= mem[eng_row_i][eng_col_i];
    eng_row_q    <= eng_row_i;
    eng_col_q    <= eng_col_i;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      host_rvalid_o <= 1'b0;
      eng_valid_q   <= 1'b0;
    end else begin
      host_rvalid_o <= host_re_i;
      eng_valid_q   <= eng_re_i;
    end
  end

  assign eng_item_o = '{valid: eng_valid_q,
                        row:   MAX_IDX_W'(eng_row_q),
                        col:   MAX_IDX_W'(eng_col_q),
                        value: eng_value_q};

  // host side is gated by busy at the top
  a_no_host_wr_on_wb: assert property (@(posedge clk) disable iff (!rst_n)
    !(host_we_i && wb_item_i.valid));

endmodule

// File: hdl/mask_rowmax.sv
`timescale 1ns/1ps

module mask_rowmax #(
  parameter  int unsigned T     = 8,
  localparam int unsigned IDX_W = $clog2(T)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  attn_pkg::sweep_pass_t  pass_i,
  input  logic [T-1:0]           pad_valid_i,
  input  logic                   causal_en_i,
  input  attn_pkg::score_item_t  item_i,
  output attn_pkg::sub_req_t     sub_req_o
);
  import attn_pkg::*;

  logic [IDX_W-1:0] in_row;
  logic [IDX_W-1:0] in_col;
  logic             in_masked;

  logic             m_valid_q;
  logic [IDX_W-1:0] m_row_q;
  logic [IDX_W-1:0] m_col_q;
  fp32_t            m_value_q;

  fp32_t            rowmax_q [T];

  // monotonic integer key, larger float gives larger key
  function automatic logic [31:0] order_key(input fp32_t v);
    return v.raw[31] ? ~v.raw : {1'b1, v.raw[30:0]};
  endfunction

  // ==========================================================================
  // padding and causal masks
  // ==========================================================================
  assign in_row    = item_i.row[IDX_W-1:0];
  assign in_col    = item_i.col[IDX_W-1:0];
  assign in_masked = !pad_valid_i[in_col] || (causal_en_i && (in_col > in_row));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid_q <= 1'b0;
    end else begin
      m_valid_q <= item_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    m_row_q       <= in_row;
    m_col_q       <= in_col;
    m_value_q.raw <= in_masked ? FP32_NINF : item_i.value.raw;
  end

  // ==========================================================================
  // per-row maximum
  // ==========================================================================
  // column 0 always loads, so no clear between runs
  always_ff @(posedge clk) begin
    if (m_valid_q && (pass_i == PASS_MAX)) begin
      if ((m_col_q == '0) || (order_key(m_value_q) > order_key(rowmax_q[m_row_q]))) begin
        rowmax_q[m_row_q] <= m_value_q;
      end
    end
  end

  assign sub_req_o.item   = '{valid: m_valid_q && (pass_i == PASS_SUB),
                              row:   MAX_IDX_W'(m_row_q),
                              col:   MAX_IDX_W'(m_col_q),
                              value: m_value_q};
  assign sub_req_o.rowmax = rowmax_q[m_row_q];

  a_col_in_tile: assert property (@(posedge clk) disable iff (!rst_n)
    item_i.valid |-> (32'(item_i.col) < T));

endmodule

// File: hdl/fp32_sub.sv
`timescale 1ns/1ps

module fp32_sub #(
  parameter  int unsigned T     = 8,
  localparam int unsigned IDX_W = $clog2(T)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  attn_pkg::sub_req_t     req_i,
  output attn_pkg::score_item_t  wb_item_o
);
  import attn_pkg::*;

  // operand decode
  fp32_t        a_op;
  fp32_t        b_op;
  logic [30:0]  a_mag;
  logic [30:0]  b_mag;
  logic [23:0]  a_sig;
  logic [23:0]  b_sig;
  logic         nb_sign;
  logic         swap;
  logic         eff_sub;
  logic [23:0]  big_sig;
  logic [23:0]  small_sig;
  logic [7:0]   big_exp;
  logic [7:0]   exp_diff;
  logic [4:0]   shamt;
  logic [58:0]  shifted;
  logic         sticky;
  logic [27:0]  big_ext;
  logic [27:0]  small_ext;
  logic [27:0]  sum_d;
  logic         sign_d;
  logic         ninf_d;

  // stage 1 registers
  logic             s1_valid_q;
  logic [IDX_W-1:0] s1_row_q;
  logic [IDX_W-1:0] s1_col_q;
  logic             s1_sign_q;
  logic [7:0]       s1_exp_q;
  logic [27:0]      s1_sum_q;
  logic             s1_ninf_q;

  // normalize
  logic [4:0]        pos;
  logic [27:0]       norm;
  logic signed [9:0] exp_res;
  fp32_t             res;

  // stage 2 registers
  logic             wb_valid_q;
  logic [IDX_W-1:0] wb_row_q;
  logic [IDX_W-1:0] wb_col_q;
  fp32_t            wb_value_q;

  function automatic logic [4:0] msb_pos(input logic [27:0] v);
    logic [4:0] p;
    p = '0;
    for (int i = 0; i < 28; i++) begin
      if (v[i]) begin
        p = 5'(i);
      end
    end
    return p;
  endfunction

  // ==========================================================================
  // stage 1, align and add magnitudes
  // ==========================================================================
  always_comb begin
    a_op    = req_i.item.value;
    b_op    = req_i.rowmax;
    // subnormals flush to zero
    a_mag   = (a_op.fields.exponent == 8'd0) ? '0 : a_op.raw[30:0];
    b_mag   = (b_op.fields.exponent == 8'd0) ? '0 : b_op.raw[30:0];
    a_sig   = (a_mag == '0) ? '0 : {1'b1, a_mag[22:0]};
    b_sig   = (b_mag == '0) ? '0 : {1'b1, b_mag[22:0]};
    nb_sign = ~b_op.fields.sign;
    swap    = b_mag > a_mag;
    eff_sub = a_op.fields.sign != nb_sign;

    big_sig   = swap ? b_sig : a_sig;
    small_sig = swap ? a_sig : b_sig;
    big_exp   = swap ? b_mag[30:23] : a_mag[30:23];
    exp_diff  = big_exp - (swap ? a_mag[30:23] : b_mag[30:23]);
    shamt     = (exp_diff > 8'd31) ? 5'd31 : exp_diff[4:0];

    // 3 guard bits, everything below them folds into sticky
    shifted   = {small_sig, 35'b0} >> shamt;
    sticky    = |shifted[31:0];
    big_ext   = {1'b0, big_sig, 3'b0};
    small_ext = {1'b0, shifted[58:32]};

    // dropped bits on a subtract pull the result one step toward zero
    if (eff_sub) begin
      sum_d = big_ext - small_ext - {27'b0, sticky};
    end else begin
      sum_d = big_ext + small_ext;
    end
    sign_d = swap ? nb_sign : a_op.fields.sign;
    ninf_d = (b_op.raw == FP32_NINF) || (a_op.raw == FP32_NINF);
  end

  always_ff @(posedge clk) begin
    s1_row_q  <= req_i.item.row[IDX_W-1:0];
    s1_col_q  <= req_i.item.col[IDX_W-1:0];
    s1_sign_q <= sign_d;
    s1_exp_q  <= big_exp;
    s1_sum_q  <= sum_d;
    s1_ninf_q <= ninf_d;
  end

  // ==========================================================================
  // stage 2, normalize, truncate, pack
  // ==========================================================================
  always_comb begin
    pos     = msb_pos(s1_sum_q);
    norm    = (pos == 5'd27) ? (s1_sum_q >> 1) : (s1_sum_q << (5'd26 - pos));
    exp_res = 10'(s1_exp_q) + 10'(pos) - 10'd26;
    res.raw = FP32_POS_ZERO;
    if (s1_ninf_q) begin
      res.raw = FP32_NINF;
    end else if ((s1_sum_q == '0) || (exp_res <= 10'sd0)) begin
      res.raw = FP32_POS_ZERO;
    end else if (exp_res >= 10'sd255) begin
      res.raw = {s1_sign_q, 8'hFF, 23'b0};
    end else begin
      res.fields.sign     = s1_sign_q;
      res.fields.exponent = exp_res[7:0];
      res.fields.mantissa = norm[25:3];
    end
  end

  always_ff @(posedge clk) begin
    wb_row_q   <= s1_row_q;
    wb_col_q   <= s1_col_q;
    wb_value_q <= res;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      wb_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_i.item.valid;
      wb_valid_q <= s1_valid_q;
    end
  end

  assign wb_item_o = '{valid: wb_valid_q,
                       row:   MAX_IDX_W'(wb_row_q),
                       col:   MAX_IDX_W'(wb_col_q),
                       value: wb_value_q};

endmodule

// File: hdl/presoft_ctrl.sv
`timescale 1ns/1ps

module presoft_ctrl #(
  parameter  int unsigned T     = 8,
  localparam int unsigned IDX_W = $clog2(T)
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  output logic                   ack_o,
  output logic                   busy_o,
  output attn_pkg::sweep_pass_t  pass_o,
  output logic                   eng_re_o,
  output logic [IDX_W-1:0]       eng_row_o,
  output logic [IDX_W-1:0]       eng_col_o
);
  import attn_pkg::*;

  // cycles to flush the pipe after the last issue of each pass
  localparam int unsigned MAX_DRAIN = 2;
  localparam int unsigned SUB_DRAIN = 4;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MAX_SWEEP,
    ST_MAX_DRAIN,
    ST_SUB_SWEEP,
    ST_SUB_DRAIN,
    ST_ACK
  } state_t;

  state_t           state_q;
  logic [IDX_W-1:0] row_q;
  logic [IDX_W-1:0] col_q;
  logic [1:0]       drain_q;
  logic             last_issue;

  assign last_issue = (row_q == IDX_W'(T - 1)) && (col_q == IDX_W'(T - 1));

  // ==========================================================================
  // handshake and pass sequencing
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      drain_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_MAX_SWEEP;
          end
        end
        ST_MAX_SWEEP: begin
          if (last_issue) begin
            drain_q <= 2'(MAX_DRAIN - 1);
            state_q <= ST_MAX_DRAIN;
          end
        end
        ST_MAX_DRAIN: begin
          drain_q <= drain_q - 1'b1;
          if (drain_q == '0) begin
            state_q <= ST_SUB_SWEEP;
          end
        end
        ST_SUB_SWEEP: begin
          if (last_issue) begin
            drain_q <= 2'(SUB_DRAIN - 1);
            state_q <= ST_SUB_DRAIN;
          end
        end
        ST_SUB_DRAIN: begin
          drain_q <= drain_q - 1'b1;
          if (drain_q == '0) begin
            state_q <= ST_ACK;
          end
        end
        ST_ACK: begin
          // hold ack until the host lets go of req
          if (!req_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // row-major walk, wraps back to 0,0 after the last entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_q <= '0;
      col_q <= '0;
    end else if (eng_re_o) begin
      col_q <= col_q + 1'b1;
      if (col_q == IDX_W'(T - 1)) begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  always_comb begin
    eng_re_o = (state_q == ST_MAX_SWEEP) || (state_q == ST_SUB_SWEEP);
    busy_o   = (state_q != ST_IDLE) && (state_q != ST_ACK);
    ack_o    = (state_q == ST_ACK);
    if ((state_q == ST_SUB_SWEEP) || (state_q == ST_SUB_DRAIN)) begin
      pass_o = PASS_SUB;
    end else begin
      pass_o = PASS_MAX;
    end
  end

  assign eng_row_o = row_q;
  assign eng_col_o = col_q;

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_o) |-> req_i);

endmodule

// File: hdl/presoft_top.sv
`timescale 1ns/1ps

module presoft_top #(
  parameter  int unsigned T     = 8,
  localparam int unsigned IDX_W = $clog2(T)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             host_we_i,
  input  logic             host_re_i,
  input  logic [IDX_W-1:0] host_row_i,
  input  logic [IDX_W-1:0] host_col_i,
  input  attn_pkg::fp32_t  host_wdata_i,
  output attn_pkg::fp32_t  host_rdata_o,
  output logic             host_rvalid_o,
  input  logic [T-1:0]     pad_valid_i,
  input  logic             causal_en_i,
  input  logic             req_i,
  output logic             ack_o,
  output logic             busy_o
);
  import attn_pkg::*;

  sweep_pass_t      pass;
  logic             eng_re;
  logic [IDX_W-1:0] eng_row;
  logic [IDX_W-1:0] eng_col;
  score_item_t      eng_item;
  sub_req_t         sub_req;
  score_item_t      wb_item;

  // ==========================================================================
  // controller and storage
  // ==========================================================================
  presoft_ctrl #(.T(T)) presoft_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (req_i),
    .ack_o     (ack_o),
    .busy_o    (busy_o),
    .pass_o    (pass),
    .eng_re_o  (eng_re),
    .eng_row_o (eng_row),
    .eng_col_o (eng_col)
  );

  // host writes are dropped while a run is active
  score_buffer #(.T(T)) score_buffer_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_we_i     (host_we_i && !busy_o),
    .host_re_i     (host_re_i),
    .host_row_i    (host_row_i),
    .host_col_i    (host_col_i),
    .host_wdata_i  (host_wdata_i),
    .host_rdata_o  (host_rdata_o),
    .host_rvalid_o (host_rvalid_o),
    .eng_re_i      (eng_re),
    .eng_row_i     (eng_row),
    .eng_col_i     (eng_col),
    .eng_item_o    (eng_item),
    .wb_item_i     (wb_item)
  );

  // ==========================================================================
  // datapath
  // ==========================================================================
  mask_rowmax #(.T(T)) mask_rowmax_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pass_i      (pass),
    .pad_valid_i (pad_valid_i),
    .causal_en_i (causal_en_i),
    .item_i      (eng_item),
    .sub_req_o   (sub_req)
  );

  fp32_sub #(.T(T)) fp32_sub_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (sub_req),
    .wb_item_o (wb_item)
  );

endmodule

// File: tests/presoft_checker.sv
`timescale 1ns/1ps

module presoft_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        host_rvalid_i,
  input logic [31:0] host_rdata_i
);

  // expected read data in read order, with the test that produced it
  string       name_q [$];
  logic [31:0] exp_q [$];

  int mismatches   = 0;
  int other_errors = 0;

  task automatic push_expected(input string name, input logic [31:0] value);
    name_q.push_back(name);
    exp_q.push_back(value);
  endtask

  function automatic int mismatch_count();
    return mismatches;
  endfunction

  function automatic int other_count();
    return other_errors;
  endfunction

  function automatic int pending();
    return exp_q.size();
  endfunction

  // ==========================================================================
  // compare on the falling edge, read data is stable there
  // ==========================================================================
  always @(negedge clk) begin : compare_read
    string       name;
    logic [31:0] expected;
    if (rst_n && host_rvalid_i) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("read data 0x%08h returned while no read was expected", host_rdata_i);
      end else begin
        name     = name_q.pop_front();
        expected = exp_q.pop_front();
        if (host_rdata_i !== expected) begin
          mismatches++;
          $display("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                   name, expected, host_rdata_i);
        end
        // after subtracting the row max nothing may be above zero
        if ((host_rdata_i != 32'h0) && !host_rdata_i[31]) begin
          other_errors++;
          $display("result 0x%08h in %s is greater than zero", host_rdata_i, name);
        end
      end
    end
  end

endmodule

// File: tests/tb_presoft.sv
`timescale 1ns/1ps

module tb_presoft;
  import attn_pkg::*;

  localparam int unsigned T          = 8;
  localparam int unsigned IDX_W      = $clog2(T);
  localparam int unsigned NUM_RUNS   = 5;
  localparam int unsigned RUN_CYCLES = 2 * T * T + 8;
  // each run writes a tile, runs both passes and reads the tile back
  localparam int unsigned WATCHDOG_CYCLES = NUM_RUNS * (T * T + RUN_CYCLES + T * T + 50);

  logic             clk;
  logic             rst_n;
  logic             host_we;
  logic             host_re;
  logic [IDX_W-1:0] host_row;
  logic [IDX_W-1:0] host_col;
  logic [31:0]      host_wdata;
  logic [31:0]      host_rdata;
  logic             host_rvalid;
  logic [T-1:0]     pad_valid;
  logic             causal_en;
  logic             req;
  logic             ack;
  logic             busy;

  logic [31:0] lfsr_state = 32'he266e8d3;
  logic [31:0] score_mem [T][T];
  logic [31:0] expected [T][T];
  int          hs_errors = 0;
  int          total_errors;

  presoft_top #(.T(T)) presoft_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_we_i     (host_we),
    .host_re_i     (host_re),
    .host_row_i    (host_row),
    .host_col_i    (host_col),
    .host_wdata_i  (host_wdata),
    .host_rdata_o  (host_rdata),
    .host_rvalid_o (host_rvalid),
    .pad_valid_i   (pad_valid),
    .causal_en_i   (causal_en),
    .req_i         (req),
    .ack_o         (ack),
    .busy_o        (busy)
  );

  presoft_checker presoft_checker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .host_rvalid_i (host_rvalid),
    .host_rdata_i  (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================================
  // random source and reference model
  // ==========================================================================
  function automatic logic lfsr_step();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // exponent kept in 100..150 so every score is normal
  function automatic logic [31:0] random_score();
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] m;
    s = lfsr_bits(1);
    e = 32'd100 + (lfsr_bits(6) % 32'd51);
    m = lfsr_bits(23);
    return {s[0], e[7:0], m[22:0]};
  endfunction

  // sign and magnitude compare, -inf sits below every finite value
  function automatic logic fp_greater(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) begin
      return b[31];
    end
    if (a[31]) begin
      return a[30:0] < b[30:0];
    end
    return a[30:0] > b[30:0];
  endfunction

  // value minus rowmax with the exact difference truncated to 24 significant bits
  function automatic logic [31:0] sub_ref(input logic [31:0] a, input logic [31:0] b);
    logic [299:0] va;
    logic [299:0] vb;
    logic [299:0] d;
    logic [299:0] sig;
    logic         sign;
    int           ea;
    int           eb;
    int           e0;
    int           p;
    int           ex;
    if (b == FP32_NINF || a == FP32_NINF) begin
      return FP32_NINF;
    end
    ea = int'(a[30:23]);
    eb = int'(b[30:23]);
    va = (ea == 0) ? '0 : 300'({1'b1, a[22:0]});
    vb = (eb == 0) ? '0 : 300'({1'b1, b[22:0]});
    // a flushed zero takes the other exponent so the shifts stay small
    if (ea == 0) begin
      ea = (eb == 0) ? 1 : eb;
    end
    if (eb == 0) begin
      eb = ea;
    end
    e0 = (ea < eb) ? ea : eb;
    va = va << (ea - e0);
    vb = vb << (eb - e0);
    if (a[31] != b[31]) begin
      d    = va + vb;
      sign = a[31];
    end else if (va >= vb) begin
      d    = va - vb;
      sign = a[31];
    end else begin
      d    = vb - va;
      sign = ~a[31];
    end
    if (d == '0) begin
      return FP32_POS_ZERO;
    end
    p = 0;
    for (int i = 0; i < 300; i++) begin
      if (d[i]) begin
        p = i;
      end
    end
    sig = (p >= 23) ? (d >> (p - 23)) : (d << (23 - p));
    ex  = e0 + p - 23;
    if (ex <= 0) begin
      return FP32_POS_ZERO;
    end
    if (ex >= 255) begin
      return {sign, 8'hFF, 23'b0};
    end
    return {sign, 8'(ex), sig[22:0]};
  endfunction

  function automatic void build_expected(input logic [T-1:0] pad, input logic causal);
    logic [31:0] masked [T][T];
    logic [31:0] rmax [T];
    for (int r = 0; r < T; r++) begin
      for (int c = 0; c < T; c++) begin
        masked[r][c] = (!pad[c] || (causal && c > r)) ? FP32_NINF : score_mem[r][c];
        if (c == 0 || fp_greater(masked[r][c], rmax[r])) begin
          rmax[r] = masked[r][c];
        end
      end
    end
    for (int r = 0; r < T; r++) begin
      for (int c = 0; c < T; c++) begin
        expected[r][c] = sub_ref(masked[r][c], rmax[r]);
      end
    end
  endfunction

  // ==========================================================================
  // host side tasks
  // ==========================================================================
  task automatic write_tile();
    for (int r = 0; r < T; r++) begin
      for (int c = 0; c < T; c++) begin
        score_mem[r][c] = random_score();
        host_we    = 1'b1;
        host_row   = IDX_W'(r);
        host_col   = IDX_W'(c);
        host_wdata = score_mem[r][c];
        @(posedge clk);
        #1;
      end
    end
    host_we = 1'b0;
  endtask

  task automatic run_handshake(input string name);
    int cycles;
    cycles = 0;
    req = 1'b1;
    @(posedge clk);
    #1;
    while (!ack && cycles < 2 * RUN_CYCLES) begin
      if (!busy) begin
        hs_errors++;
        $display("%s: busy is low while the run is still going", name);
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ack) begin
      hs_errors++;
      $display("%s: ack never rose after req", name);
    end
    @(posedge clk);
    #1;
    if (!ack) begin
      hs_errors++;
      $display("%s: ack dropped while req was still high", name);
    end
    req    = 1'b0;
    cycles = 0;
    while (ack && cycles < 4) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (ack || busy) begin
      hs_errors++;
      $display("%s: ack or busy still high after req dropped", name);
    end
  endtask

  task automatic read_tile(input string name);
    for (int r = 0; r < T; r++) begin
      for (int c = 0; c < T; c++) begin
        presoft_checker_inst.push_expected(name, expected[r][c]);
        host_re  = 1'b1;
        host_row = IDX_W'(r);
        host_col = IDX_W'(c);
        @(posedge clk);
        #1;
      end
    end
    host_re = 1'b0;
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic do_run(input string name, input logic [T-1:0] pad, input logic causal);
    write_tile();
    pad_valid = pad;
    causal_en = causal;
    build_expected(pad, causal);
    run_handshake(name);
    read_tile(name);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    rst_n      = 1'b0;
    host_we    = 1'b0;
    host_re    = 1'b0;
    host_row   = '0;
    host_col   = '0;
    host_wdata = '0;
    pad_valid  = '1;
    causal_en  = 1'b0;
    req        = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    do_run("random_nomask", 8'hFF, 1'b0);
    do_run("pad_mask", 8'b1011_0110, 1'b0);
    do_run("causal", 8'hFF, 1'b1);
    do_run("all_padded", 8'h00, 1'b0);
    do_run("second_run", 8'hFF, 1'b0);

    if (presoft_checker_inst.pending() != 0) begin
      hs_errors++;
      $display("%0d expected reads never came back", presoft_checker_inst.pending());
    end
    total_errors = presoft_checker_inst.mismatch_count()
                 + presoft_checker_inst.other_count() + hs_errors;
    $display("errors: mismatches=%0d other=%0d handshake=%0d",
             presoft_checker_inst.mismatch_count(),
             presoft_checker_inst.other_count(), hs_errors);
    if (total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: flist.f
hdl/attn_pkg.sv
hdl/score_buffer.sv
hdl/mask_rowmax.sv
hdl/fp32_sub.sv
hdl/presoft_ctrl.sv
hdl/presoft_top.sv
tests/presoft_checker.sv
tests/tb_presoft.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_presoft
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
